// File: all.f
+incdir+.
tomasuloPkg.sv
regFile.sv
robQueue.sv
aluStation.sv
cdbArbiter.sv
renameCore.sv
tbRenameCore.sv

// File: Bender.yml
package:
  name: renamecore

sources:
  - files:
      - tomasuloPkg.sv
      - regFile.sv
      - robQueue.sv
      - aluStation.sv
      - cdbArbiter.sv
      - renameCore.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbRenameCore.sv

// File: tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] lfsrState = 32'ha380_db1a;
dataT        refRegs [32] = '{default: '0};
regNameT     expRd [$];
dataT        expData [$];

// Galois LFSR. Each bit taken costs one step.
function automatic logic [31:0] takeBits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsrState[0]};
        if (lfsrState[0]) begin
            lfsrState = (lfsrState >> 1) ^ 32'h8020_0003;
        end else begin
            lfsrState = lfsrState >> 1;
        end
    end
    return bits;
endfunction

// Expected result of one operation.
function automatic dataT refResult(opT op, dataT a, dataT b, dataT imm);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_LI:   return imm;
        default: return '0;
    endcase
endfunction

// Sequential model, one instruction at a time in program order.
task automatic modelInstr(opT op, regNameT rd, regNameT rs1, regNameT rs2, dataT imm);
    dataT result;
    result = refResult(op, refRegs[rs1], refRegs[rs2], imm);
    if (rd == '0) begin
        result = '0; // x0 never changes.
    end else begin
        refRegs[rd] = result;
    end
    expRd.push_back(rd);
    expData.push_back(result);
endtask

`endif

// File: tbRenameCore.sv
`timescale 1ns/1ps

module tbRenameCore;
    import tomasuloPkg::*;

    localparam int ROB_DEPTH   = 8;
    localparam int CLK_PERIOD  = 100;
    localparam int TOTAL_INSTR = 10 + 7 + 5 + 16 + 300; // Instructions over all five tests.

    logic    clk = 1'b0;
    logic    rst;
    logic    instrValid;
    opT      instrOp;
    regNameT instrRd;
    regNameT instrRs1;
    regNameT instrRs2;
    dataT    instrImm;
    logic    instrCredit;
    logic    commitValid;
    regNameT commitRd;
    dataT    commitData;

    int    credits;
    int    sent;
    int    commits;
    int    inFlight;
    int    checks;
    int    errors;
    int    testSent;
    int    testErrors;
    bit    sawFull;
    string testName;

    `include "tbRefModel.svh"

    renameCore #(.ROB_DEPTH(ROB_DEPTH)) UUT (
        .clk(clk), .rst(rst),
        .instrValid(instrValid), .instrOp(instrOp), .instrRd(instrRd),
        .instrRs1(instrRs1), .instrRs2(instrRs2), .instrImm(instrImm),
        .instrCredit(instrCredit), .commitValid(commitValid),
        .commitRd(commitRd), .commitData(commitData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic noteError();
        errors++;
        testErrors++;
    endtask

    // One clock, returning a credit for each commit pulse.
    task automatic tick();
        @(posedge clk);
        instrValid <= 1'b0;
        if (instrCredit) begin
            credits++;
        end
    endtask

    task automatic sendInstr(opT op, regNameT rd, regNameT rs1, regNameT rs2, dataT imm);
        tick();
        while (credits == 0) begin
            tick();
        end
        instrValid <= 1'b1;
        instrOp    <= op;
        instrRd    <= rd;
        instrRs1   <= rs1;
        instrRs2   <= rs2;
        instrImm   <= imm;
        credits--;
        sent++;
        testSent++;
        if (credits == 0) begin
            sawFull = 1'b1;
        end
        modelInstr(op, rd, rs1, rs2, imm);
    endtask

    task automatic startTest(string name);
        testName   = name;
        testSent   = 0;
        testErrors = 0;
        sawFull    = 1'b0;
    endtask

    // All slots back means every instruction has committed.
    task automatic endTest();
        while (credits != ROB_DEPTH) begin
            tick();
        end
        tick();
        $display("%s: %0d instructions, %0d errors", testName, testSent, testErrors);
    endtask

    task automatic randomTest(int n);
        opT      op;
        regNameT rd;
        regNameT rs1;
        regNameT rs2;
        dataT    imm;
        for (int i = 0; i < n; i++) begin
            op  = opT'(3'(takeBits(3) % 6));
            rd  = regNameT'(takeBits(5));
            rs1 = regNameT'(takeBits(5));
            rs2 = regNameT'(takeBits(5));
            imm = takeBits(32);
            sendInstr(op, rd, rs1, rs2, imm);
        end
    endtask

    always @(posedge clk) begin : checkCommits
        regNameT eRd;
        dataT    eData;
        if (!rst) begin
            if (instrValid) begin
                inFlight++;
            end
            if (commitValid) begin
                inFlight--;
                commits++;
                checks++;
                assert (expRd.size() != 0) else begin
                    $display("ERROR in %s: commit to x%0d with no instruction outstanding",
                             testName, commitRd);
                    noteError();
                end
                if (expRd.size() != 0) begin
                    eRd   = expRd.pop_front();
                    eData = expData.pop_front();
                    assert (commitRd == eRd && commitData == eData) else begin
                        $display("FAIL %s: expected x%0d = %h, actual x%0d = %h",
                                 testName, eRd, eData, commitRd, commitData);
                        noteError();
                    end
                end
            end
            assert (instrCredit == commitValid) else begin
                $display("ERROR in %s: credit pulse does not match a commit", testName);
                noteError();
            end
            assert (inFlight <= ROB_DEPTH) else begin
                $display("ERROR in %s: %0d instructions in flight with only %0d slots",
                         testName, inFlight, ROB_DEPTH);
                noteError();
            end
        end
    end

    initial begin
        #(TOTAL_INSTR * 20 * CLK_PERIOD);
        $display("ERROR: run timed out with %0d of %0d instructions committed", commits, sent);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instrOp    = OP_ADD;
        instrRd    = '0;
        instrRs1   = '0;
        instrRs2   = '0;
        instrImm   = '0;
        credits    = ROB_DEPTH;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        startTest("loadImm");
        for (int i = 1; i <= 5; i++) begin
            sendInstr(OP_LI, regNameT'(i), '0, '0, 32'h1357_9bdf * i);
        end
        for (int i = 1; i <= 5; i++) begin
            sendInstr(OP_ADD, regNameT'(20 + i), regNameT'(i), '0, '0);
        end
        endTest();

        startTest("depChain");
        sendInstr(OP_LI, 5'd6, '0, '0, 32'd7);
        sendInstr(OP_ADD, 5'd7, 5'd6, 5'd6, '0);
        sendInstr(OP_SUB, 5'd8, 5'd7, 5'd1, '0);
        sendInstr(OP_XOR, 5'd9, 5'd8, 5'd7, '0);
        sendInstr(OP_AND, 5'd10, 5'd9, 5'd2, '0);
        repeat (3) tick(); // Producer done but maybe not yet committed.
        sendInstr(OP_OR, 5'd11, 5'd10, 5'd9, '0);
        sendInstr(OP_ADD, 5'd6, 5'd11, 5'd6, '0);
        endTest();

        startTest("sameDest");
        sendInstr(OP_LI, 5'd12, '0, '0, 32'haaaa_0000);
        sendInstr(OP_OR, 5'd12, 5'd11, 5'd9, '0);
        sendInstr(OP_ADD, 5'd13, 5'd12, '0, '0);
        sendInstr(OP_ADD, 5'd14, 5'd12, '0, '0); // Older write gone, younger still pending.
        sendInstr(OP_SUB, 5'd15, 5'd12, 5'd13, '0);
        endTest();

        startTest("fullBurst");
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 1) begin
                sendInstr(OP_LI, regNameT'(24 + i % 8), '0, '0, 32'(i * 3 + 1));
            end else begin
                sendInstr(OP_ADD, regNameT'(24 + i % 8), regNameT'(1 + i % 5),
                          regNameT'(21 + i % 5), '0);
            end
        end
        assert (sawFull) else begin
            $display("ERROR in %s: the burst never used up all credits", testName);
            noteError();
        end
        endTest();

        startTest("random");
        randomTest(300);
        endTest();

        assert (commits == sent) else begin
            $display("ERROR: %0d instructions sent but %0d committed", sent, commits);
            noteError();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: renameCore.sv
`timescale 1ns/1ps

module renameCore #(
    parameter int ROB_DEPTH = 8,
    parameter int TAG_W     = $clog2(ROB_DEPTH + 1)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  tomasuloPkg::opT      instrOp,
    input  tomasuloPkg::regNameT instrRd,
    input  tomasuloPkg::regNameT instrRs1,
    input  tomasuloPkg::regNameT instrRs2,
    input  tomasuloPkg::dataT    instrImm,
    output logic                 instrCredit,
    output logic                 commitValid,
    output tomasuloPkg::regNameT commitRd,
    output tomasuloPkg::dataT    commitData
);
    import tomasuloPkg::*;

    logic [TAG_W-1:0] allocTag;
    logic [TAG_W-1:0] commitTag;
    dataT             rs1Data;
    dataT             rs2Data;
    logic [TAG_W-1:0] rs1Tag;
    logic [TAG_W-1:0] rs2Tag;
    logic             issueValid;
    logic             issueSel;
    opT               issueOp;
    dataT             issueA;
    dataT             issueB;
    dataT             issueImm;
    logic [TAG_W-1:0] issueATag;
    logic [TAG_W-1:0] issueBTag;
    logic [TAG_W-1:0] issueTag;
    logic             free0;
    logic             free1;
    logic             req0;
    logic             req1;
    logic             grant0;
    logic             grant1;
    logic [TAG_W-1:0] resTag0;
    logic [TAG_W-1:0] resTag1;
    dataT             resData0;
    dataT             resData1;
    logic             cdbValid;
    logic [TAG_W-1:0] cdbTag;
    dataT             cdbData;

    regFile #(.TAG_W(TAG_W)) regs (
        .clk(clk), .rst(rst),
        .dispValid(instrValid), .dispRd(instrRd), .dispRs1(instrRs1), .dispRs2(instrRs2),
        .allocTag(allocTag),
        .rs1Data(rs1Data), .rs1Tag(rs1Tag), .rs2Data(rs2Data), .rs2Tag(rs2Tag),
        .commitValid(commitValid), .commitRd(commitRd),
        .commitData(commitData), .commitTag(commitTag)
    );

    robQueue #(.ROB_DEPTH(ROB_DEPTH), .TAG_W(TAG_W)) rob (
        .clk(clk), .rst(rst),
        .instrValid(instrValid), .instrOp(instrOp), .instrRd(instrRd), .instrImm(instrImm),
        .rs1Data(rs1Data), .rs1Tag(rs1Tag), .rs2Data(rs2Data), .rs2Tag(rs2Tag),
        .stationFree0(free0), .stationFree1(free1),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .allocTag(allocTag), .instrCredit(instrCredit),
        .issueValid(issueValid), .issueSel(issueSel), .issueOp(issueOp),
        .issueA(issueA), .issueATag(issueATag), .issueB(issueB), .issueBTag(issueBTag),
        .issueImm(issueImm), .issueTag(issueTag),
        .commitValid(commitValid), .commitRd(commitRd),
        .commitData(commitData), .commitTag(commitTag)
    );

    aluStation #(.ALU_LAT(1), .TAG_W(TAG_W)) alu0 (
        .clk(clk), .rst(rst), .issueValid(issueValid && !issueSel),
        .issueOp(issueOp), .issueA(issueA), .issueATag(issueATag),
        .issueB(issueB), .issueBTag(issueBTag), .issueImm(issueImm), .issueTag(issueTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData), .cdbGrant(grant0),
        .free(free0), .cdbReq(req0), .resTag(resTag0), .resData(resData0)
    );

    aluStation #(.ALU_LAT(3), .TAG_W(TAG_W)) alu1 (
        .clk(clk), .rst(rst), .issueValid(issueValid && issueSel),
        .issueOp(issueOp), .issueA(issueA), .issueATag(issueATag),
        .issueB(issueB), .issueBTag(issueBTag), .issueImm(issueImm), .issueTag(issueTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData), .cdbGrant(grant1),
        .free(free1), .cdbReq(req1), .resTag(resTag1), .resData(resData1)
    );

    cdbArbiter #(.TAG_W(TAG_W)) arb (
        .clk(clk), .rst(rst),
        .req0(req0), .req1(req1),
        .tag0(resTag0), .data0(resData0), .tag1(resTag1), .data1(resData1),
        .grant0(grant0), .grant1(grant1),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );

endmodule

// File: cdbArbiter.sv
`timescale 1ns/1ps

module cdbArbiter #(
    parameter int TAG_W = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req0,
    input  logic              req1,
    input  logic [TAG_W-1:0]  tag0,
    input  tomasuloPkg::dataT data0,
    input  logic [TAG_W-1:0]  tag1,
    input  tomasuloPkg::dataT data1,
    output logic              grant0,
    output logic              grant1,
    output logic              cdbValid,
    output logic [TAG_W-1:0]  cdbTag,
    output tomasuloPkg::dataT cdbData
);

    logic prio; // High favors station 1.

    assign grant0   = req0 && (!req1 || !prio);
    assign grant1   = req1 && (!req0 || prio);
    assign cdbValid = req0 || req1;
    assign cdbTag   = grant1 ? tag1 : tag0;
    assign cdbData  = grant1 ? data1 : data0;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= 1'b0;
        end else if (grant0) begin
            prio <= 1'b1;
        end else if (grant1) begin
            prio <= 1'b0;
        end
    end

endmodule

// File: aluStation.sv
`timescale 1ns/1ps

module aluStation #(
    parameter int ALU_LAT = 1,
    parameter int TAG_W   = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              issueValid,
    input  tomasuloPkg::opT   issueOp,
    input  tomasuloPkg::dataT issueA,
    input  logic [TAG_W-1:0]  issueATag,
    input  tomasuloPkg::dataT issueB,
    input  logic [TAG_W-1:0]  issueBTag,
    input  tomasuloPkg::dataT issueImm,
    input  logic [TAG_W-1:0]  issueTag,
    input  logic              cdbValid,
    input  logic [TAG_W-1:0]  cdbTag,
    input  tomasuloPkg::dataT cdbData,
    input  logic              cdbGrant,
    output logic              free,
    output logic              cdbReq,
    output logic [TAG_W-1:0]  resTag,
    output tomasuloPkg::dataT resData
);
    import tomasuloPkg::*;

    localparam int CNT_W = $clog2(ALU_LAT + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;     // Remaining execute cycles.
    logic             opsReady;
    opT               op;
    dataT             a;
    dataT             b;
    dataT             imm;
    logic [TAG_W-1:0] aTag;
    logic [TAG_W-1:0] bTag;
    logic [TAG_W-1:0] tag;

    assign opsReady = (aTag == '0) && (bTag == '0);
    assign free     = !busy;
    assign cdbReq   = busy && opsReady && (cnt == '0); // Held until granted.
    assign resTag   = tag;
    assign resData  = evalOp(op, a, b, imm);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (issueValid) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(ALU_LAT - 1);
        end else if (cdbGrant) begin
            busy <= 1'b0;
        end else if (busy && opsReady && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            op   <= issueOp;
            a    <= issueA;
            aTag <= issueATag;
            b    <= issueB;
            bTag <= issueBTag;
            imm  <= issueImm;
            tag  <= issueTag;
        end else begin
            if (busy && cdbValid && aTag != '0 && cdbTag == aTag) begin
                a    <= cdbData;
                aTag <= '0;
            end
            if (busy && cdbValid && bTag != '0 && cdbTag == bTag) begin
                b    <= cdbData;
                bTag <= '0;
            end
        end
    end

endmodule

// File: robQueue.sv
`timescale 1ns/1ps

module robQueue #(
    parameter int ROB_DEPTH = 8,
    parameter int TAG_W     = $clog2(ROB_DEPTH + 1)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  tomasuloPkg::opT      instrOp,
    input  tomasuloPkg::regNameT instrRd,
    input  tomasuloPkg::dataT    instrImm,
    input  tomasuloPkg::dataT    rs1Data,
    input  logic [TAG_W-1:0]     rs1Tag,
    input  tomasuloPkg::dataT    rs2Data,
    input  logic [TAG_W-1:0]     rs2Tag,
    input  logic                 stationFree0,
    input  logic                 stationFree1,
    input  logic                 cdbValid,
    input  logic [TAG_W-1:0]     cdbTag,
    input  tomasuloPkg::dataT    cdbData,
    output logic [TAG_W-1:0]     allocTag,
    output logic                 instrCredit,
    output logic                 issueValid,
    output logic                 issueSel,
    output tomasuloPkg::opT      issueOp,
    output tomasuloPkg::dataT    issueA,
    output logic [TAG_W-1:0]     issueATag,
    output tomasuloPkg::dataT    issueB,
    output logic [TAG_W-1:0]     issueBTag,
    output tomasuloPkg::dataT    issueImm,
    output logic [TAG_W-1:0]     issueTag,
    output logic                 commitValid,
    output tomasuloPkg::regNameT commitRd,
    output tomasuloPkg::dataT    commitData,
    output logic [TAG_W-1:0]     commitTag
);
    import tomasuloPkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic [IDX_W-1:0]     head;
    logic [IDX_W-1:0]     tail;
    logic [IDX_W-1:0]     issuePtr;
    logic [ROB_DEPTH-1:0] slotValid;
    logic [ROB_DEPTH-1:0] slotIssued;
    logic [ROB_DEPTH-1:0] slotDone;
    opT                   slotOp     [ROB_DEPTH];
    regNameT              slotRd     [ROB_DEPTH];
    dataT                 slotA      [ROB_DEPTH];
    logic [TAG_W-1:0]     slotATag   [ROB_DEPTH];
    dataT                 slotB      [ROB_DEPTH];
    logic [TAG_W-1:0]     slotBTag   [ROB_DEPTH];
    dataT                 slotImm    [ROB_DEPTH];
    dataT                 slotResult [ROB_DEPTH];

    function automatic logic [IDX_W-1:0] slotOf(logic [TAG_W-1:0] tag);
        return IDX_W'(tag - 1'b1);
    endfunction

    // An operand wakes from the bus or from a slot that already completed.
    function automatic logic [TAG_W-1:0] wakeTag(logic [TAG_W-1:0] tag);
        if (tag != '0 && ((cdbValid && cdbTag == tag) || slotDone[slotOf(tag)])) begin
            return '0;
        end
        return tag;
    endfunction

    function automatic dataT wakeVal(logic [TAG_W-1:0] tag, dataT val);
        if (tag == '0) begin
            return val;
        end
        if (cdbValid && cdbTag == tag) begin
            return cdbData;
        end
        if (slotDone[slotOf(tag)]) begin
            return slotResult[slotOf(tag)];
        end
        return val;
    endfunction

    assign allocTag    = TAG_W'(tail) + 1'b1;
    assign issueTag    = TAG_W'(issuePtr) + 1'b1;
    assign commitTag   = TAG_W'(head) + 1'b1;
    assign commitValid = slotValid[head] && slotDone[head];
    assign commitRd    = slotRd[head];
    assign commitData  = (slotRd[head] == '0) ? '0 : slotResult[head]; // x0 stays zero.
    assign instrCredit = commitValid; // One slot returned per commit.

    always_comb begin
        issueValid = slotValid[issuePtr] && !slotIssued[issuePtr]
                     && (stationFree0 || stationFree1);
        issueSel   = !stationFree0; // Station 0 first.
        issueOp    = slotOp[issuePtr];
        issueATag  = wakeTag(slotATag[issuePtr]);
        issueA     = wakeVal(slotATag[issuePtr], slotA[issuePtr]);
        issueBTag  = wakeTag(slotBTag[issuePtr]);
        issueB     = wakeVal(slotBTag[issuePtr], slotB[issuePtr]);
        issueImm   = slotImm[issuePtr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            issuePtr   <= '0;
            slotValid  <= '0;
            slotIssued <= '0;
            slotDone   <= '0;
        end else begin
            if (cdbValid) begin
                slotDone[slotOf(cdbTag)] <= 1'b1;
            end
            if (issueValid) begin
                slotIssued[issuePtr] <= 1'b1;
                issuePtr             <= issuePtr + 1'b1;
            end
            if (commitValid) begin
                slotValid[head]  <= 1'b0;
                slotIssued[head] <= 1'b0;
                slotDone[head]   <= 1'b0;
                head             <= head + 1'b1;
            end
            if (instrValid) begin
                slotValid[tail]  <= 1'b1;
                slotIssued[tail] <= 1'b0;
                slotDone[tail]   <= 1'b0;
                tail             <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            slotATag[i] <= wakeTag(slotATag[i]);
            slotA[i]    <= wakeVal(slotATag[i], slotA[i]);
            slotBTag[i] <= wakeTag(slotBTag[i]);
            slotB[i]    <= wakeVal(slotBTag[i], slotB[i]);
        end
        if (cdbValid) begin
            slotResult[slotOf(cdbTag)] <= cdbData;
        end
        if (instrValid) begin
            slotOp[tail]   <= instrOp;
            slotRd[tail]   <= instrRd;
            slotImm[tail]  <= instrImm;
            slotATag[tail] <= wakeTag(rs1Tag);
            slotA[tail]    <= wakeVal(rs1Tag, rs1Data);
            slotBTag[tail] <= wakeTag(rs2Tag);
            slotB[tail]    <= wakeVal(rs2Tag, rs2Data);
        end
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int TAG_W = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispValid,
    input  tomasuloPkg::regNameT dispRd,
    input  tomasuloPkg::regNameT dispRs1,
    input  tomasuloPkg::regNameT dispRs2,
    input  logic [TAG_W-1:0]     allocTag,
    output tomasuloPkg::dataT    rs1Data,
    output logic [TAG_W-1:0]     rs1Tag,
    output tomasuloPkg::dataT    rs2Data,
    output logic [TAG_W-1:0]     rs2Tag,
    input  logic                 commitValid,
    input  tomasuloPkg::regNameT commitRd,
    input  tomasuloPkg::dataT    commitData,
    input  logic [TAG_W-1:0]     commitTag
);
    import tomasuloPkg::*;

    dataT             regVal [32];
    logic [TAG_W-1:0] regTag [32];

    // Commit value is forwarded to a same-cycle reader.
    function automatic dataT readVal(regNameT name);
        if (commitValid && commitRd != '0 && commitRd == name) begin
            return commitData;
        end
        return regVal[name];
    endfunction

    function automatic logic [TAG_W-1:0] readTag(regNameT name);
        if (commitValid && commitRd == name && regTag[name] == commitTag) begin
            return '0;
        end
        return regTag[name];
    endfunction

    always_comb begin
        rs1Data = readVal(dispRs1);
        rs1Tag  = readTag(dispRs1);
        rs2Data = readVal(dispRs2);
        rs2Tag  = readTag(dispRs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regVal[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            if (commitValid && commitRd != '0) begin
                regVal[commitRd] <= commitData;
                if (regTag[commitRd] == commitTag) begin
                    regTag[commitRd] <= '0; // Younger rename keeps its tag.
                end
            end
            if (dispValid && dispRd != '0) begin
                regTag[dispRd] <= allocTag; // Overrides a same-cycle clear.
            end
        end
    end

endmodule

// File: tomasuloPkg.sv
package tomasuloPkg;

    typedef logic [31:0] dataT;
    typedef logic [4:0] regNameT;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LI
    } opT;

    // Sources are ignored for OP_LI.
    function automatic dataT evalOp(opT op, dataT a, dataT b, dataT imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_LI:   return imm;
            default: return '0;
        endcase
    endfunction

endpackage
